// File: verilog/hmul_pkg.sv
package hmul_pkg;

	// binary16 field widths
	localparam int EXP_W    = 5;
	localparam int MAN_W    = 10;
	localparam int SIG_W    = MAN_W + 1;  // Significand with hidden one
	localparam int PROD_W   = 2 * SIG_W;  // Full significand product, 22 bits

	// Exponent constants
	localparam int EXP_BIAS = 15;
	localparam int EXP_MAX  = 31;  // All-ones exponent, Inf or NaN

	// One half-precision value, sign in the MSB
	typedef struct packed {
		logic             sign;
		logic [EXP_W-1:0] exp;
		logic [MAN_W-1:0] man;
	} fp16_t;

	// Canonical quiet NaN, positive sign
	localparam fp16_t QNAN = 16'h7E00;

	// Exception vector, same bit order as the legacy FPMult flags
	typedef struct packed {
		logic any_exc;  // Some input is NaN or Inf
		logic a_nan;
		logic b_nan;
		logic a_inf;
		logic b_inf;
	} mul_flags_t;

	// Stage 1 payload, 41 bits
	typedef struct packed {
		logic              sign_a;
		logic              sign_b;
		logic [EXP_W-1:0]  exp_a;   // Raw biased exponents
		logic [EXP_W-1:0]  exp_b;
		logic [PROD_W-1:0] prod;    // 1.m x 1.m, binary point after bit 20
		logic              a_zero;  // Zero or subnormal
		logic              b_zero;
		mul_flags_t        flags;
	} unpack_t;

	// Stage 2 payload, 26 bits
	typedef struct packed {
		logic              sign;
		logic signed [6:0] exp;     // Biased result exponent, may go negative
		logic [MAN_W-1:0]  man;     // Bits after the leading one
		logic              guard;
		logic              sticky;
		logic              zero;    // Either operand zero
		mul_flags_t        flags;
	} norm_t;

	// Final result with its flags, 21 bits
	typedef struct packed {
		fp16_t      value;
		mul_flags_t flags;
	} mul_result_t;

endpackage

// File: verilog/fp16_unpack.sv
`timescale 1ns/1ps

module fp16_unpack (
	input  hmul_pkg::fp16_t   a,
	input  hmul_pkg::fp16_t   b,
	output hmul_pkg::unpack_t u
);
	import hmul_pkg::*;

	logic             a_exp_ones;  // Exponent all ones
	logic             b_exp_ones;
	logic             a_man_nz;    // Mantissa non-zero
	logic             b_man_nz;
	logic             a_nan;
	logic             b_nan;
	logic             a_inf;
	logic             b_inf;
	logic [SIG_W-1:0] sig_a;
	logic [SIG_W-1:0] sig_b;

	// Classify operands
	assign a_exp_ones = (a.exp == EXP_W'(EXP_MAX));
	assign b_exp_ones = (b.exp == EXP_W'(EXP_MAX));
	assign a_man_nz   = |a.man;
	assign b_man_nz   = |b.man;

	assign a_nan = a_exp_ones & a_man_nz;
	assign b_nan = b_exp_ones & b_man_nz;
	assign a_inf = a_exp_ones & ~a_man_nz;
	assign b_inf = b_exp_ones & ~b_man_nz;

	// Hidden one always set, zero operands are caught by the flags
	assign sig_a = {1'b1, a.man};
	assign sig_b = {1'b1, b.man};

	always_comb begin
		u.sign_a = a.sign;
		u.sign_b = b.sign;
		u.exp_a  = a.exp;
		u.exp_b  = b.exp;
		u.prod   = sig_a * sig_b;       // 11x11 unsigned, fits in 22 bits
		u.a_zero = (a.exp == '0);       // Subnormals count as zero
		u.b_zero = (b.exp == '0);

		// Exception vector
		u.flags.any_exc = a_nan | b_nan | a_inf | b_inf;
		u.flags.a_nan   = a_nan;
		u.flags.b_nan   = b_nan;
		u.flags.a_inf   = a_inf;
		u.flags.b_inf   = b_inf;
	end

endmodule

// File: verilog/fp16_mant_norm.sv
`timescale 1ns/1ps

module fp16_mant_norm (
	input  hmul_pkg::unpack_t u,
	output hmul_pkg::norm_t   n
);
	import hmul_pkg::*;

	logic [PROD_W-1:0] p;
	logic              hi;       // Product in [2,4)
	logic [PROD_W-1:0] p_norm;   // Leading one moved to bit 21
	logic [6:0]        exp_sum;

	assign p  = u.prod;
	assign hi = p[PROD_W-1];

	// One-bit normalization shifts left when the product is in [1,2)
	assign p_norm = hi ? p : (p << 1);

	// Ea + Eb - bias plus one for the [2,4) case
	// Seven bits so the sum can go below zero without wrapping into range
	assign exp_sum = 7'(u.exp_a) + 7'(u.exp_b) + 7'(hi) - 7'(EXP_BIAS);

	always_comb begin
		n.sign = u.sign_a ^ u.sign_b;  // Equal signs give a positive product
		n.exp  = exp_sum;

		// Ten bits after the leading one
		n.man  = p_norm[PROD_W-2 -: MAN_W];

		// First dropped bit
		n.guard = p_norm[PROD_W-2-MAN_W];

		// Everything below guard
		n.sticky = |p_norm[PROD_W-3-MAN_W:0];

		n.zero  = u.a_zero | u.b_zero;
		n.flags = u.flags;             // Carried to the output as is
	end

endmodule

// File: verilog/fp16_round_pack.sv
`timescale 1ns/1ps

module fp16_round_pack (
	input  hmul_pkg::norm_t       n,
	output hmul_pkg::mul_result_t r
);
	import hmul_pkg::*;

	logic              round_up;
	logic [MAN_W:0]    man_r;    // Extra bit catches the rounding carry
	logic signed [6:0] exp_r;
	logic              any_inf;
	logic              is_nan;
	logic              ovf;
	logic              unf;

	// Round to nearest, ties to even
	assign round_up = n.guard & (n.sticky | n.man[0]);
	assign man_r    = {1'b0, n.man} + {{MAN_W{1'b0}}, round_up};

	// Carry out means 1.111.. rounded to 10.000.., mantissa bits already zero
	assign exp_r = n.exp + $signed({6'b0, man_r[MAN_W]});

	assign any_inf = n.flags.a_inf | n.flags.b_inf;
	assign is_nan  = n.flags.a_nan | n.flags.b_nan | (any_inf & n.zero);  // Inf x 0 too

	assign ovf = (exp_r >= EXP_MAX);
	assign unf = (exp_r <= 0);       // Would be subnormal or less

	always_comb begin
		r.flags      = n.flags;
		r.value.sign = n.sign;
		r.value.exp  = exp_r[EXP_W-1:0];
		r.value.man  = man_r[MAN_W-1:0];

		// Special cases, highest priority first
		if (is_nan) begin
			r.value = QNAN;
		end else if (any_inf) begin
			r.value.exp = EXP_W'(EXP_MAX);  // Signed infinity
			r.value.man = '0;
		end else if (n.zero) begin
			r.value.exp = '0;               // Signed zero
			r.value.man = '0;
		end else if (ovf) begin
			r.value.exp = EXP_W'(EXP_MAX);
			r.value.man = '0;
		end else if (unf) begin
			r.value.exp = '0;               // Flush to zero, sign kept
			r.value.man = '0;
		end
	end

	// Any NaN leaving the block must be the canonical one,
	// whichever path through the priority chain produced it
	always_comb begin
		if (r.value.exp == EXP_W'(EXP_MAX) && r.value.man != '0) begin
			nan_is_canonical: assert (r.value == QNAN)
				else $error("non-canonical NaN %h", r.value);
		end
	end

endmodule

// File: verilog/fp16_mul_pipe.sv
`timescale 1ns/1ps

module fp16_mul_pipe (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  en,
	input  hmul_pkg::fp16_t       a,
	input  hmul_pkg::fp16_t       b,
	output hmul_pkg::mul_result_t res
);
	import hmul_pkg::*;

	unpack_t     u_d;  // Stage 1 comb output
	unpack_t     s1;
	norm_t       n_d;  // Stage 2 comb output
	norm_t       s2;
	mul_result_t r_d;  // Stage 3 comb output
	mul_result_t s3;

	// Classify and multiply significands
	fp16_unpack u_unpack (
		.a (a),
		.b (b),
		.u (u_d)
	);

	// Sign, exponent, normalize, guard/sticky
	fp16_mant_norm u_mant_norm (
		.u (s1),
		.n (n_d)
	);

	// Round and apply special values
	fp16_round_pack u_round_pack (
		.n (s2),
		.r (r_d)
	);

	// Whole pipe moves together on en, stalls otherwise
	always_ff @(posedge clk) begin
		if (rst) begin
			s1 <= '0;
			s2 <= '0;
			s3 <= '0;
		end else if (en) begin
			s1 <= u_d;
			s2 <= n_d;
			s3 <= r_d;
		end
	end

	assign res = s3;  // Output straight from the last register

	// A stalled cycle never changes the result register
	s3_held_on_stall: assert property (
		@(posedge clk) disable iff (rst)
		(!$past(en) && !$past(rst)) |-> $stable(s3)
	) else $error("s3 changed while en was low");

endmodule

// File: verilog/hmul_top.sv
`timescale 1ns/1ps

module hmul_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ce,
	input  hmul_pkg::fp16_t      din0,
	input  hmul_pkg::fp16_t      din1,
	output hmul_pkg::fp16_t      dout,
	output hmul_pkg::mul_flags_t flags
);
	import hmul_pkg::*;

	fp16_t       din0_buf;  // Input buffer
	fp16_t       din1_buf;
	logic        ce_r;      // ce delayed one cycle to drive the core
	mul_result_t res;       // Core output
	mul_result_t hold;      // Last result seen while ce_r was high

	fp16_mul_pipe u_mul_pipe (
		.clk (clk),
		.rst (rst),
		.en  (ce_r),
		.a   (din0_buf),
		.b   (din1_buf),
		.res (res)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			din0_buf <= '0;
			din1_buf <= '0;
			ce_r     <= 1'b0;
			hold     <= '0;
		end else begin
			ce_r <= ce;
			if (ce) begin
				din0_buf <= din0;
				din1_buf <= din1;
			end
			if (ce_r)
				hold <= res;  // Track the core while it runs
		end
	end

	// Core output bypasses the hold register while ce_r is high
	assign dout  = ce_r ? res.value : hold.value;
	assign flags = ce_r ? res.flags : hold.flags;

	// A stall keeps the last shown result on the outputs
	dout_held_on_stall: assert property (
		@(posedge clk) disable iff (rst)
		(!ce_r && !$past(rst)) |-> $stable({dout, flags})
	) else $error("dout changed during stall");

endmodule

// File: test/tb_hmul_top.sv
`timescale 1ns/1ps

module tb_hmul_top;
	import hmul_pkg::*;

	// Table row whose name sits in the names queue
	typedef struct packed {
		fp16_t      a;
		fp16_t      b;
		fp16_t      val;    // Expected product
		mul_flags_t flags;  // Expected exception vector
		logic [3:0] gap;    // ce-low cycles after this row
	} vec_t;

	localparam int DRAIN_LIMIT = 20;  // Cycles allowed for the pipe to empty

	logic       clk;
	logic       rst;
	logic       ce;
	fp16_t      din0;
	fp16_t      din1;
	fp16_t      dout;
	mul_flags_t flags;

	vec_t  vecs[$];
	string names[$];
	int    cap_count[$];  // Enabled-edge count at which each row was buffered
	int    en_count;      // Enabled edges since reset
	int    next_chk;      // Oldest row not yet compared
	int    pass_count;
	int    fail_count;
	int    seed;
	logic  timed_out;

	hmul_top u_hmul_top (
		.clk   (clk),
		.rst   (rst),
		.ce    (ce),
		.din0  (din0),
		.din1  (din1),
		.dout  (dout),
		.flags (flags)
	);

	always #5 clk = ~clk;

	// Edges that move data through the operator
	always @(posedge clk) begin
		if (rst)
			en_count <= 0;
		else if (ce)
			en_count <= en_count + 1;
	end

	task automatic compare(input string name, input mul_result_t expected,
			input mul_result_t actual);
		if (actual !== expected) begin
			$display("error %s: expected %h flags %b, actual %h flags %b", name,
				expected.value, expected.flags, actual.value, actual.flags);
			fail_count++;
		end else begin
			$display("ok    %s: %h flags %b", name, actual.value, actual.flags);
			pass_count++;
		end
	endtask

	task automatic add_row(input string name, input fp16_t a, input fp16_t b,
			input fp16_t val, input mul_flags_t fl, input int gap);
		vec_t v;
		v.a     = a;
		v.b     = b;
		v.val   = val;
		v.flags = fl;
		v.gap   = 4'(gap);
		vecs.push_back(v);
		names.push_back(name);
	endtask

	// Products worked out by hand from the binary16 rules
	task automatic load_table();
		add_row("one_x_one",       16'h3C00, 16'h3C00, 16'h3C00, 5'b00000, 0);
		add_row("two_x_three",     16'h4000, 16'h4200, 16'h4600, 5'b00000, 0);
		add_row("neg_x_two",       16'hBE00, 16'h4000, 16'hC200, 5'b00000, 0);
		add_row("tie_up_to_one",   16'h3555, 16'h4200, 16'h3C00, 5'b00000, 1);  // 4095/4096
		add_row("tie_stays_even",  16'h3E00, 16'h3C03, 16'h3E04, 5'b00000, 0);
		add_row("truncate",        16'h3C01, 16'h3C01, 16'h3C02, 5'b00000, 0);
		add_row("round_up_sticky", 16'h3E01, 16'h3E01, 16'h4082, 5'b00000, 0);  // Product >= 2
		add_row("nan_x_one",       16'h7C01, 16'h3C00, 16'h7E00, 5'b11000, 3);  // Stall follows
		add_row("one_x_neg_nan",   16'h3C00, 16'hFE00, 16'h7E00, 5'b10100, 0);
		add_row("inf_x_zero",      16'h7C00, 16'h0000, 16'h7E00, 5'b10010, 0);
		add_row("inf_x_neg_two",   16'h7C00, 16'hC000, 16'hFC00, 5'b10010, 0);
		add_row("one_x_neg_inf",   16'h3C00, 16'hFC00, 16'hFC00, 5'b10001, 0);
		add_row("neg_zero_x_one",  16'h8000, 16'h3C00, 16'h8000, 5'b00000, 0);
		add_row("subnormal_x_two", 16'h8001, 16'h4000, 16'h8000, 5'b00000, 0);  // Input DAZ
		add_row("overflow",        16'h7BFF, 16'h4000, 16'h7C00, 5'b00000, 0);
		add_row("underflow",       16'h0400, 16'h0400, 16'h0000, 5'b00000, 0);  // 2^-28
	endtask

	function automatic mul_result_t expected_of(input int idx);
		return {vecs[idx].val, vecs[idx].flags};
	endfunction

	// Result shows three enabled edges after its buffer edge
	task automatic check_due();
		if (next_chk < cap_count.size() && cap_count[next_chk] == en_count - 3) begin
			compare(names[next_chk], expected_of(next_chk), {dout, flags});
			next_chk++;
		end
	endtask

	task automatic issue_row(input int idx);
		din0 = vecs[idx].a;
		din1 = vecs[idx].b;
		ce   = 1'b1;
		cap_count.push_back(en_count + 1);  // Count once the next edge lands
		@(negedge clk);
	endtask

	// Random operands with ce low must not reach the pipe
	task automatic stall(input int cycles, input string after);
		ce = 1'b0;
		for (int i = 0; i < cycles; i++) begin
			din0 = 16'($random(seed));
			din1 = 16'($random(seed));
			@(negedge clk);
			compare($sformatf("stall %0d after %s", i + 1, after),
				expected_of(next_chk - 1), {dout, flags});  // Last shown result
		end
	endtask

	// Idle operands with ce high until every row is compared
	task automatic drain();
		int cycles;
		cycles = 0;
		din0   = '0;
		din1   = '0;
		ce     = 1'b1;
		while (next_chk < vecs.size() && !timed_out) begin
			check_due();
			if (next_chk < vecs.size()) begin
				if (cycles == DRAIN_LIMIT) begin
					$display("timeout: %0d results still missing after %0d cycles",
						vecs.size() - next_chk, cycles);
					timed_out = 1'b1;
				end else begin
					@(negedge clk);
					cycles++;
				end
			end
		end
	endtask

	initial begin
		seed       = 61;
		clk        = 1'b0;
		rst        = 1'b1;
		ce         = 1'b0;
		din0       = '0;
		din1       = '0;
		next_chk   = 0;
		pass_count = 0;
		fail_count = 0;
		timed_out  = 1'b0;
		load_table();

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		compare("after_reset", '0, {dout, flags});  // No enabled edge yet

		// Back to back with one row per cycle
		for (int i = 0; i < vecs.size(); i++) begin
			check_due();
			issue_row(i);
			if (vecs[i].gap != 0) begin
				check_due();
				stall(int'(vecs[i].gap), names[i]);
			end
		end
		drain();

		// Reset in the middle of traffic with 2 x 2 products in every stage
		din0 = 16'h4000;
		din1 = 16'h4000;
		ce   = 1'b1;
		repeat (4) @(negedge clk);
		compare("full_before_reset", {16'h4400, 5'b00000}, {dout, flags});
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst  = 1'b0;
		ce   = 1'b0;
		din0 = '0;
		din1 = '0;
		compare("reset_mid_stream", '0, {dout, flags});

		// Cleared stages come out as zeros
		ce = 1'b1;
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			compare($sformatf("cleared_stage_%0d", i + 1), '0, {dout, flags});
		end

		$display("%0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0 && !timed_out)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: hmul.f
verilog/hmul_pkg.sv
verilog/fp16_unpack.sv
verilog/fp16_mant_norm.sv
verilog/fp16_round_pack.sv
verilog/fp16_mul_pipe.sv
verilog/hmul_top.sv
test/tb_hmul_top.sv

// File: Makefile
BIN  := obj_dir/Vtb_hmul_top
SRCS := $(wildcard verilog/*.sv test/*.sv)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): hmul.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f hmul.f --top-module tb_hmul_top

# Fails unless the pass line shows up in the output
run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir
